/* source/vic_consts.svh */
`ifndef VIC_CONSTS_SVH
`define VIC_CONSTS_SVH

// --------------------
// datapath widths
// --------------------
`define VIC_X_W             10
`define VIC_Y_W             9
`define VIC_CYC_W           7

// last raster x per chip, line length is x_max + 1 pixels
`define VIC_X_MAX_6567R8    10'd519
`define VIC_X_MAX_6567R56A  10'd511
`define VIC_X_MAX_6569      10'd503

// last raster line per chip
`define VIC_Y_MAX_6567R8    9'd262
`define VIC_Y_MAX_6567R56A  9'd261
`define VIC_Y_MAX_6569      9'd311

// dot4x ticks in one phi half
`define VIC_PHASE_STEPS     16

// --------------------
// badline and bus window
// --------------------
`define VIC_DMA_FIRST_LINE  9'd48
`define VIC_DMA_END_LINE    9'd248
`define VIC_BA_FIRST_CYCLE  7'd12
`define VIC_BA_LAST_CYCLE   7'd54
// phi cycles of ba low before aec is held low
`define VIC_AEC_DELAY       3

// register window, offsets from $d000
`define VIC_REG_CTRL1       6'h11
`define VIC_REG_RASTER      6'h12
`define VIC_REG_IRQ_STATUS  6'h19
`define VIC_REG_IRQ_ENABLE  6'h1A

`endif

/* source/vic_pkg.sv */
`include "vic_consts.svh"

package vic_pkg;

    // chip select, the unused code runs as a 6569
    typedef enum logic [1:0] {
        CHIP_6567R8,
        CHIP_6567R56A,
        CHIP_6569,
        CHIP_UNUSED
    } chip_e;

    // mapped register offsets
    typedef enum logic [5:0] {
        REG_CTRL1      = `VIC_REG_CTRL1,
        REG_RASTER     = `VIC_REG_RASTER,
        REG_IRQ_STATUS = `VIC_REG_IRQ_STATUS,
        REG_IRQ_ENABLE = `VIC_REG_IRQ_ENABLE
    } reg_addr_e;

    // --------------------
    // wishbone classic
    // --------------------
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [5:0] adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // --------------------
    // timing core
    // --------------------
    // step counts 0..15 inside the current phi half
    typedef struct packed {
        logic       clk_phi;
        logic [3:0] step;
        logic       pixel_tick;
    } phase_t;

    typedef struct packed {
        logic [`VIC_X_W-1:0]   raster_x;
        logic [`VIC_CYC_W-1:0] cycle_num;
        logic [`VIC_Y_W-1:0]   raster_line;
        logic                  line_start;
    } raster_t;

    // fields of $d011 that the bus logic needs
    typedef struct packed {
        logic       den;
        logic       rsel;
        logic [2:0] yscroll;
    } vic_ctrl_t;

endpackage

/* source/phase_gen.sv */
`include "vic_consts.svh"

module phase_gen (
    input  logic            clk_dot4x,
    input  logic            rst,
    output vic_pkg::phase_t phase_o
);

    // final step before phi flips
    localparam logic [3:0] STEP_LAST = 4'(`VIC_PHASE_STEPS - 1);

    logic       phi_q;
    logic [3:0] step_q;

    // --------------------
    // step counter
    // --------------------
    // reset lands on step 0 of the low half
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            step_q <= 4'd0;
            phi_q  <= 1'b0;
        end else begin
            if (step_q == STEP_LAST) begin
                step_q <= 4'd0;
                // phi half ends, flip
                phi_q  <= ~phi_q;
            end else begin
                step_q <= step_q + 4'd1;
            end
        end
    end

    assign phase_o.clk_phi    = phi_q;
    assign phase_o.step       = step_q;
    // last tick of each pixel, 4 pixels per phi half
    assign phase_o.pixel_tick = (step_q[1:0] == 2'b11);

    // phi may only move across the wrap of the step counter
    assert property (@(posedge clk_dot4x) disable iff (rst)
        $changed(phi_q) |-> ($past(step_q) == STEP_LAST) && (step_q == 4'd0));

endmodule

/* source/raster_counter.sv */
`include "vic_consts.svh"

module raster_counter (
    input  logic             clk_dot4x,
    input  logic             rst,
    input  vic_pkg::chip_e   chip_i,
    input  vic_pkg::phase_t  phase_i,
    output vic_pkg::raster_t raster_o
);

    import vic_pkg::*;

    chip_e               chip_q;
    logic [`VIC_X_W-1:0] x_max;
    logic [`VIC_Y_W-1:0] y_max;
    logic [`VIC_X_W-1:0] raster_x_q;
    logic [`VIC_Y_W-1:0] raster_line_q;
    logic                line_start_q;

    // chip type is captured while reset is held
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            chip_q <= chip_i;
        end
    end

    // --------------------
    // per chip limits
    // --------------------
    always_comb begin
        case (chip_q)
            CHIP_6567R8: begin
                x_max = `VIC_X_MAX_6567R8;
                y_max = `VIC_Y_MAX_6567R8;
            end
            CHIP_6567R56A: begin
                x_max = `VIC_X_MAX_6567R56A;
                y_max = `VIC_Y_MAX_6567R56A;
            end
            // 6569 timing, also for the spare code
            default: begin
                x_max = `VIC_X_MAX_6569;
                y_max = `VIC_Y_MAX_6569;
            end
        endcase
    end

    // x advances once per pixel, line on the x wrap
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_q    <= '0;
            raster_line_q <= '0;
            line_start_q  <= 1'b0;
        end else begin
            line_start_q <= 1'b0;
            if (phase_i.pixel_tick) begin
                if (raster_x_q == x_max) begin
                    raster_x_q   <= '0;
                    line_start_q <= 1'b1;
                    if (raster_line_q == y_max) begin
                        raster_line_q <= '0;
                    end else begin
                        raster_line_q <= raster_line_q + `VIC_Y_W'(1);
                    end
                end else begin
                    raster_x_q <= raster_x_q + `VIC_X_W'(1);
                end
            end
        end
    end

    assign raster_o.raster_x    = raster_x_q;
    // 8 pixels per phi cycle
    assign raster_o.cycle_num   = raster_x_q[`VIC_X_W-1:3];
    assign raster_o.raster_line = raster_line_q;
    assign raster_o.line_start  = line_start_q;

    // frame height follows the chip captured at reset
    assert property (@(posedge clk_dot4x) disable iff (rst) raster_line_q <= y_max);

endmodule

/* source/vic_registers.sv */
`include "vic_consts.svh"

module vic_registers (
    input  logic               clk_dot4x,
    input  logic               rst,
    input  vic_pkg::wb_req_t   wb_req_i,
    output vic_pkg::wb_rsp_t   wb_rsp_o,
    input  vic_pkg::raster_t   raster_i,
    output vic_pkg::vic_ctrl_t ctrl_o,
    output logic               irq_o
);

    import vic_pkg::*;

    // bus handshake
    logic                rearm_q;
    logic                ack_q;
    logic [7:0]          rd_dat_q;
    logic                access;
    logic                wr_en;
    logic [7:0]          rd_mux;

    // register contents
    vic_ctrl_t           ctrl_q;
    logic [`VIC_Y_W-1:0] compare_q;
    logic                erst_q;

    // raster interrupt
    logic                match;
    logic                fire;
    logic                fired_q;
    logic                irst_q;
    logic                irq_q;

    // --------------------
    // wishbone slave
    // --------------------
    // one access per strobe, stb must drop before the next one
    assign access = wb_req_i.cyc && wb_req_i.stb && rearm_q;
    assign wr_en  = access && wb_req_i.we;

    always_comb begin
        case (reg_addr_e'(wb_req_i.adr))
            REG_CTRL1:      rd_mux = {raster_i.raster_line[8], 2'b00, ctrl_q.den,
                                      ctrl_q.rsel, ctrl_q.yscroll};
            REG_RASTER:     rd_mux = raster_i.raster_line[7:0];
            REG_IRQ_STATUS: rd_mux = {irq_q, 6'b000000, irst_q};
            REG_IRQ_ENABLE: rd_mux = {7'b0000000, erst_q};
            // unmapped offsets float high
            default:        rd_mux = 8'hFF;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            rearm_q <= 1'b1;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            if (access) begin
                rearm_q <= 1'b0;
            end else if (!wb_req_i.stb) begin
                rearm_q <= 1'b1;
            end
        end
    end

    // read data sampled with the access, presented with ack
    always_ff @(posedge clk_dot4x) begin
        if (access) begin
            rd_dat_q <= rd_mux;
        end
    end

    // writes, unmapped offsets are dropped
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl_q    <= '0;
            compare_q <= '0;
            erst_q    <= 1'b0;
        end else if (wr_en) begin
            case (reg_addr_e'(wb_req_i.adr))
                REG_CTRL1: begin
                    compare_q[8]   <= wb_req_i.dat[7];
                    ctrl_q.den     <= wb_req_i.dat[4];
                    ctrl_q.rsel    <= wb_req_i.dat[3];
                    ctrl_q.yscroll <= wb_req_i.dat[2:0];
                end
                REG_RASTER:     compare_q[7:0] <= wb_req_i.dat;
                REG_IRQ_ENABLE: erst_q <= wb_req_i.dat[0];
                default: ;
            endcase
        end
    end

    // --------------------
    // raster compare
    // --------------------
    // a new line rearms the compare, at most one hit per line
    assign match = (raster_i.raster_line == compare_q);
    assign fire  = match && (raster_i.line_start || !fired_q);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // the line present at reset never matches
            fired_q <= 1'b1;
            irst_q  <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            if (raster_i.line_start) begin
                fired_q <= match;
            end else if (match) begin
                fired_q <= 1'b1;
            end
            // write 1 clears, a hit on the same tick wins
            if (fire) begin
                irst_q <= 1'b1;
            end else if (wr_en && (reg_addr_e'(wb_req_i.adr) == REG_IRQ_STATUS)
                         && wb_req_i.dat[0]) begin
                irst_q <= 1'b0;
            end
            irq_q <= irst_q && erst_q;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_dat_q;
    assign ctrl_o       = ctrl_q;
    assign irq_o        = irq_q;

    // single cycle ack, always answering a strobe on the previous edge
    assert property (@(posedge clk_dot4x) disable iff (rst) ack_q |=> !ack_q);
    assert property (@(posedge clk_dot4x) disable iff (rst)
        ack_q |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

/* source/bus_arbiter.sv */
`include "vic_consts.svh"

module bus_arbiter (
    input  logic               clk_dot4x,
    input  logic               rst,
    input  vic_pkg::phase_t    phase_i,
    input  vic_pkg::raster_t   raster_i,
    input  vic_pkg::vic_ctrl_t ctrl_i,
    output logic               ba_o,
    output logic               aec_o
);

    localparam logic [3:0] STEP_LAST = 4'(`VIC_PHASE_STEPS - 1);

    logic                     cycle_start;
    logic                     in_dma_span;
    logic                     ba_window;
    logic                     allow_d;
    logic                     allow_q;
    logic                     badline_d;
    logic                     badline_q;
    logic                     ba_q;
    logic [`VIC_AEC_DELAY-1:0] ba_hist_q;
    logic                     aec_hold;
    logic                     aec_q;

    // first tick of a phi cycle, x sits on a multiple of 8 here
    assign cycle_start = !phase_i.clk_phi && (phase_i.step == 4'd0);

    // --------------------
    // badline detection
    // --------------------
    assign in_dma_span = (raster_i.raster_line >= `VIC_DMA_FIRST_LINE) &&
                         (raster_i.raster_line < `VIC_DMA_END_LINE);

    // den seen anywhere on line 48 opens badlines for the frame
    always_comb begin
        allow_d = allow_q;
        if (ctrl_i.den && (raster_i.raster_line == `VIC_DMA_FIRST_LINE)) begin
            allow_d = 1'b1;
        end
        if (raster_i.raster_line == `VIC_DMA_END_LINE) begin
            allow_d = 1'b0;
        end
    end

    assign badline_d = allow_d && in_dma_span &&
                       (raster_i.raster_line[2:0] == ctrl_i.yscroll);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_q   <= 1'b0;
            badline_q <= 1'b0;
        end else if (cycle_start) begin
            allow_q   <= allow_d;
            badline_q <= badline_d;
        end
    end

    // --------------------
    // ba and aec
    // --------------------
    // c-access window, ba drops 3 cycles ahead of the first fetch
    assign ba_window = (raster_i.cycle_num >= `VIC_BA_FIRST_CYCLE) &&
                       (raster_i.cycle_num <= `VIC_BA_LAST_CYCLE);

    // history of ba at cycle starts, oldest in the top bit
    assign aec_hold = !ba_q && (ba_hist_q == '0);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_q      <= 1'b1;
            ba_hist_q <= '1;
            aec_q     <= 1'b0;
        end else begin
            ba_q <= !(badline_q && ba_window);
            if (cycle_start) begin
                ba_hist_q <= {ba_hist_q[`VIC_AEC_DELAY-2:0], ba_q};
            end
            // rises a tick after phi, falls together with phi
            aec_q <= phase_i.clk_phi && (phase_i.step != STEP_LAST) && !aec_hold;
        end
    end

    assign ba_o  = ba_q;
    assign aec_o = aec_q;

    // cpu never owns the bus in the vic half
    assert property (@(posedge clk_dot4x) disable iff (rst) !phase_i.clk_phi |-> !aec_q);

endmodule

/* source/vic_top.sv */
module vic_top (
    input  logic             clk_dot4x,
    input  logic             rst,
    input  vic_pkg::chip_e   chip_i,
    input  vic_pkg::wb_req_t wb_req_i,
    output vic_pkg::wb_rsp_t wb_rsp_o,
    output logic             irq_o,
    output logic             clk_phi_o,
    output logic             ba_o,
    output logic             aec_o
);

    import vic_pkg::*;

    phase_t    phase;
    raster_t   raster;
    vic_ctrl_t ctrl;

    // --------------------
    // timing chain
    // --------------------
    phase_gen phase_gen_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    raster_counter raster_counter_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .phase_i   (phase),
        .raster_o  (raster)
    );

    // cpu window and raster irq
    vic_registers vic_registers_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .wb_req_i  (wb_req_i),
        .wb_rsp_o  (wb_rsp_o),
        .raster_i  (raster),
        .ctrl_o    (ctrl),
        .irq_o     (irq_o)
    );

    // badlines steal the cpu bus
    bus_arbiter bus_arbiter_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .raster_i  (raster),
        .ctrl_i    (ctrl),
        .ba_o      (ba_o),
        .aec_o     (aec_o)
    );

    assign clk_phi_o = phase.clk_phi;

endmodule

/* tb/tb_vic_top.sv */
`include "vic_consts.svh"

module tb_vic_top;

    import vic_pkg::*;

    // --------------------
    // chip table and timing
    // --------------------
    localparam int X_MAX_R8     = int'(`VIC_X_MAX_6567R8);
    localparam int Y_MAX_R8     = int'(`VIC_Y_MAX_6567R8);
    localparam int X_MAX_R56A   = int'(`VIC_X_MAX_6567R56A);
    localparam int Y_MAX_R56A   = int'(`VIC_Y_MAX_6567R56A);
    localparam int X_MAX_6569   = int'(`VIC_X_MAX_6569);
    localparam int Y_MAX_6569   = int'(`VIC_Y_MAX_6569);
    localparam int PIXEL_TICKS  = 4;
    localparam int HALF_TICKS   = `VIC_PHASE_STEPS;
    localparam int CYCLE_TICKS  = 2 * `VIC_PHASE_STEPS;
    localparam int DMA_FIRST    = int'(`VIC_DMA_FIRST_LINE);
    localparam int DMA_END      = int'(`VIC_DMA_END_LINE);
    localparam int BA_FIRST     = int'(`VIC_BA_FIRST_CYCLE);
    localparam int BA_LAST      = int'(`VIC_BA_LAST_CYCLE);
    localparam int AEC_DELAY    = `VIC_AEC_DELAY;
    // both frames plus a tenth
    localparam int TIMEOUT_CYCLES =
        ((X_MAX_6569 + 1) * PIXEL_TICKS * (Y_MAX_6569 + 1) +
         (X_MAX_R8 + 1) * PIXEL_TICKS * (Y_MAX_R8 + 1)) * 11 / 10;

    logic       clk_dot4x;
    logic       rst;
    chip_e      chip;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       irq;
    logic       clk_phi;
    logic       ba;
    logic       aec;

    // reference model state
    int         ticks;
    int         cycles;
    int         x_max;
    int         y_max;
    int         cmp_line;
    logic [2:0] ys;
    logic       den_on;
    logic       irq_en;
    logic [4:0] ctrl_wr;
    int         value_errors;
    int         protocol_errors;

    vic_top vic_top_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .irq_o     (irq),
        .clk_phi_o (clk_phi),
        .ba_o      (ba),
        .aec_o     (aec)
    );

    always #5 clk_dot4x = ~clk_dot4x;

    // dot4x ticks since reset release
    always @(posedge clk_dot4x) begin
        if (rst) begin
            ticks <= 0;
        end else begin
            ticks <= ticks + 1;
        end
    end

    // run limit
    always @(posedge clk_dot4x) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d clock cycles, the stimulus did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // --------------------
    // raster model
    // --------------------
    function automatic int line_ticks();
        return (x_max + 1) * PIXEL_TICKS;
    endfunction

    function automatic int model_line(int t);
        return (t / line_ticks()) % (y_max + 1);
    endfunction

    function automatic int model_pos(int t);
        return t % line_ticks();
    endfunction

    function automatic logic model_phi(int t);
        return ((t / HALF_TICKS) % 2) == 1;
    endfunction

    // cpu half opens one tick after phi rises
    function automatic logic aec_expected(int t);
        return model_phi(t) && ((t % HALF_TICKS) != 0);
    endfunction

    function automatic logic is_badline(int t);
        int line;
        line = model_line(t);
        return den_on && (line >= DMA_FIRST) && (line < DMA_END) && ((line % 8) == int'(ys));
    endfunction

    // 2 tick slack on both window edges
    function automatic logic ba_may_low(int t);
        return is_badline(t) && (model_pos(t) >= BA_FIRST * CYCLE_TICKS) &&
               (model_pos(t) < (BA_LAST + 1) * CYCLE_TICKS + 2);
    endfunction

    function automatic logic ba_must_low(int t);
        return is_badline(t) && (model_pos(t) >= BA_FIRST * CYCLE_TICKS + 2) &&
               (model_pos(t) < (BA_LAST + 1) * CYCLE_TICKS);
    endfunction

    // ba low at AEC_DELAY cycle starts, held from the cycle after
    function automatic logic aec_stolen(int t);
        return is_badline(t) && (model_pos(t) >= (BA_FIRST + AEC_DELAY + 1) * CYCLE_TICKS) &&
               (model_pos(t) < (BA_LAST + 1) * CYCLE_TICKS);
    endfunction

    // --------------------
    // error reporting
    // --------------------
    function automatic void flag_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        value_errors++;
        $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
    endfunction

    function automatic void flag_problem(string msg);
        protocol_errors++;
        $display("%s", msg);
    endfunction

    // --------------------
    // timing checks
    // --------------------
    assert property (@(posedge clk_dot4x) disable iff (rst) clk_phi == model_phi(ticks))
    else flag_mismatch("clk_phi_o", 32'(model_phi(ticks)), 32'(clk_phi));

    assert property (@(posedge clk_dot4x) disable iff (rst) aec |-> clk_phi)
    else flag_problem("aec_o is high while clk_phi_o is low");

    assert property (@(posedge clk_dot4x) disable iff (rst)
        (ticks == 0) |-> (!irq && ba && !aec && !clk_phi))
    else flag_problem("outputs are not in their reset state after reset release");

    // wishbone handshake
    assert property (@(posedge clk_dot4x) disable iff (rst) $rose(wb_req.stb) |=> wb_rsp.ack)
    else flag_problem("wishbone ack missing one cycle after the strobe");

    assert property (@(posedge clk_dot4x) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
    else flag_problem("wishbone ack held longer than one cycle");

    // bus arbitration against the badline model
    assert property (@(posedge clk_dot4x) disable iff (rst) !ba |-> ba_may_low(ticks))
    else flag_mismatch("ba_o", 32'h1, 32'(ba));

    assert property (@(posedge clk_dot4x) disable iff (rst) ba_must_low(ticks) |-> !ba)
    else flag_mismatch("ba_o", 32'h0, 32'(ba));

    assert property (@(posedge clk_dot4x) disable iff (rst) aec_stolen(ticks) |-> !aec)
    else flag_mismatch("aec_o", 32'h0, 32'(aec));

    assert property (@(posedge clk_dot4x) disable iff (rst)
        !is_badline(ticks) |-> (aec == aec_expected(ticks)))
    else flag_mismatch("aec_o", 32'(aec_expected(ticks)), 32'(aec));

    // raster irq only when enabled, only near the compare line start
    assert property (@(posedge clk_dot4x) disable iff (rst) irq |-> irq_en)
    else flag_mismatch("irq_o", 32'h0, 32'(irq));

    assert property (@(posedge clk_dot4x) disable iff (rst)
        $rose(irq) |-> ((model_line(ticks) == cmp_line) && (model_pos(ticks) <= 4)))
    else flag_problem("irq_o rose away from the start of the compare line");

    // --------------------
    // stimulus tasks
    // --------------------
    // all tasks start and end 1 unit after a rising edge
    task automatic step_clock();
        @(posedge clk_dot4x);
        #1;
    endtask

    task automatic wait_tick(input int t);
        while (ticks < t) begin
            step_clock();
        end
    endtask

    task automatic wait_mid_line();
        while ((model_pos(ticks) <= 8) || (model_pos(ticks) >= line_ticks() - 16)) begin
            step_clock();
        end
    endtask

    task automatic apply_reset(input chip_e kind);
        rst  = 1'b1;
        chip = kind;
        repeat (8) @(posedge clk_dot4x);
        #1;
        rst  = 1'b0;
    endtask

    task automatic wb_access(input logic we, input logic [5:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat, output int t);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        t          = ticks;
        waited     = 0;
        do begin
            step_clock();
            waited++;
        end while (!wb_rsp.ack && (waited < 8));
        rdat = wb_rsp.dat;
        assert (wb_rsp.ack && (waited == 1))
        else flag_problem($sformatf("access to 0x%0h not acked one cycle after strobe", adr));
        wb_req = '0;
        // stb low for a cycle rearms the slave
        step_clock();
    endtask

    task automatic wb_write(input logic [5:0] adr, input logic [7:0] dat);
        logic [7:0] unused_dat;
        int         t;
        wb_access(1'b1, adr, dat, unused_dat, t);
    endtask

    task automatic check_reg(input logic [5:0] adr, input logic [7:0] exp, input string name);
        logic [7:0] rd;
        int         t;
        wb_access(1'b0, adr, 8'h00, rd, t);
        assert (rd == exp) else flag_mismatch(name, 32'(exp), 32'(rd));
    endtask

    // raster line through $12 and bit 8 of $11
    task automatic check_raster();
        logic [7:0] rd;
        int         t;
        wait_mid_line();
        wb_access(1'b0, REG_RASTER, 8'h00, rd, t);
        assert (rd == 8'(model_line(t)))
        else flag_mismatch("raster $12", 32'(model_line(t) % 256), 32'(rd));
        wait_mid_line();
        wb_access(1'b0, REG_CTRL1, 8'h00, rd, t);
        assert (rd == {1'(model_line(t) >> 8), 2'b00, ctrl_wr})
        else flag_mismatch("ctrl1 $11", 32'({1'(model_line(t) >> 8), 2'b00, ctrl_wr}),
                           32'(rd));
    endtask

    // one frame of one chip, irq_on selects the enabled irq path
    task automatic run_frame(input chip_e kind, input logic irq_on);
        int         frame;
        int         len;
        logic [8:0] cmp;
        case (kind)
            CHIP_6567R8: begin
                x_max = X_MAX_R8;
                y_max = Y_MAX_R8;
            end
            CHIP_6567R56A: begin
                x_max = X_MAX_R56A;
                y_max = Y_MAX_R56A;
            end
            default: begin
                x_max = X_MAX_6569;
                y_max = Y_MAX_6569;
            end
        endcase
        cmp_line = int'($urandom_range(40, 1));
        cmp      = 9'(cmp_line);
        ys       = 3'($urandom_range(7, 0));
        den_on   = 1'b0;
        irq_en   = 1'b0;
        ctrl_wr  = 5'h00;
        apply_reset(kind);
        len   = line_ticks();
        frame = len * (y_max + 1);

        // register window and masks
        check_reg(6'h00, 8'hFF, "unmapped $00");
        check_reg(6'h2E, 8'hFF, "unmapped $2E");
        wb_write(REG_CTRL1, 8'hEF);
        ctrl_wr = 5'h0F;
        check_raster();
        wb_write(REG_IRQ_ENABLE, 8'hFF);
        check_reg(REG_IRQ_ENABLE, 8'h01, "irq enable $1A");
        irq_en = irq_on;
        wb_write(REG_IRQ_ENABLE, {7'b0000000, irq_on});
        wb_write(REG_RASTER, cmp[7:0]);
        ctrl_wr = {2'b00, ys};
        wb_write(REG_CTRL1, {cmp[8], 2'b00, ctrl_wr});
        check_raster();

        // raster interrupt on the compare line
        wait_tick(cmp_line * len + 4);
        assert (irq == irq_on) else flag_mismatch("irq_o", 32'(irq_on), 32'(irq));
        check_reg(REG_IRQ_STATUS, {irq_on, 6'b000000, 1'b1}, "irq status $19");
        wb_write(REG_IRQ_STATUS, 8'h01);
        check_reg(REG_IRQ_STATUS, 8'h00, "irq status $19 after clear");

        // den on ahead of the dma span
        wait_tick(40 * len + len / 2);
        ctrl_wr = {2'b10, ys};
        wb_write(REG_CTRL1, {3'b000, ctrl_wr});
        den_on = 1'b1;

        // line bit 8, last line and the wrap to line 0
        wait_tick(256 * len + len / 2);
        check_raster();
        wait_tick(y_max * len + len / 2);
        check_raster();
        wait_tick(frame + len / 2);
        check_raster();

        // irq comes back on the compare line of the next frame
        if (irq_on) begin
            wait_tick(frame + cmp_line * len + 4);
            assert (irq == 1'b1) else flag_mismatch("irq_o", 32'h1, 32'(irq));
            check_reg(REG_IRQ_STATUS, 8'h81, "irq status $19 next frame");
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        clk_dot4x       = 1'b0;
        rst             = 1'b1;
        chip            = CHIP_6569;
        wb_req          = '0;
        cycles          = 0;
        x_max           = X_MAX_6569;
        y_max           = Y_MAX_6569;
        cmp_line        = 0;
        ys              = 3'd0;
        den_on          = 1'b0;
        irq_en          = 1'b0;
        ctrl_wr         = 5'h00;
        value_errors    = 0;
        protocol_errors = 0;
        void'($urandom(21));
        step_clock();
        run_frame(CHIP_6569, 1'b0);
        run_frame(CHIP_6567R8, 1'b1);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if ((value_errors + protocol_errors) == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+source
source/vic_pkg.sv
source/phase_gen.sv
source/raster_counter.sv
source/vic_registers.sv
source/bus_arbiter.sv
source/vic_top.sv
tb/tb_vic_top.sv

/* Makefile */
TOP := tb_vic_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
